//--- hw/rhythm_pkg.sv
package rhythm_pkg;

	////////////////////
	// LCD rows

	localparam int ROW_CHARS = 16;

	// Byte 0 is the leftmost character, at the top of the vector
	typedef logic [0:ROW_CHARS-1][7:0] row_t;

	localparam int JUDGE_COL = 1;

	localparam row_t END_TOP = "   GAME OVER    ";
	localparam row_t END_BOTTOM = "   GAME ENDED   ";

	////////////////////
	// Game rules

	// Entries 0..3 top lane, 4..7 bottom lane, entry i matches keys[i]
	localparam logic [0:7][7:0] note_chars = {"9", "0", "C", "D", "A", "B", "E", "F"};

	localparam int HIT_POINTS = 70;
	localparam int SCORE_MAX = 9999;
	localparam int LIVES_START = 9;

	typedef logic [13:0] score_t;
	typedef logic [3:0] lives_t;

	localparam logic [31:0] LCG_MUL = 32'd1103515245;
	localparam logic [31:0] LCG_ADD = 32'd12345;

	////////////////////
	// LCD and segment encodings

	typedef enum logic [7:0] {
		FUNCTION_SET = 8'h3C, // 8 bit, 2 lines
		DISP_ON      = 8'h0C,
		ENTRY_MODE   = 8'h06,
		LINE1_ADDR   = 8'h80,
		LINE2_ADDR   = 8'hC0
	} lcd_cmd_e;

	// Segments a..g in bits 7..1, dot in bit 0
	localparam logic [0:9][7:0] seg_digit = {
		8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66,
		8'hB6, 8'hBE, 8'hE0, 8'hFE, 8'hF6
	};

endpackage

//--- hw/play_if.sv
`timescale 1ns/1ps

interface play_if;
	import rhythm_pkg::*;

	row_t row_top;
	row_t row_bottom;
	score_t score;
	lives_t lives;
	logic game_over; // Lives ran out, rows hold the end screen

	modport core (
		output row_top, row_bottom, score, lives, game_over
	);

	modport lcd (
		input row_top, row_bottom
	);

	modport status (
		input score, lives
	);
endinterface

//--- hw/tick_divider.sv
`timescale 1ns/1ps

module tick_divider #(
	parameter int GAME_DIV = 250
) (
	input  logic clk_1khz,
	input  logic rstn,
	input  logic lcd_ready,
	output logic game_tick
);

	localparam int CNT_W = $clog2(GAME_DIV + 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk_1khz or negedge rstn) begin
		if (!rstn) begin
			cnt <= '0;
			game_tick <= 1'b0;
		end else if (!lcd_ready) begin
			cnt <= '0; // Held until the LCD is up
			game_tick <= 1'b0;
		end else if (cnt == CNT_W'(GAME_DIV - 1)) begin
			cnt <= '0;
			game_tick <= 1'b1;
		end else begin
			cnt <= cnt + 1'b1;
			game_tick <= 1'b0;
		end
	end

	a_tick_single: assert property (@(posedge clk_1khz) disable iff (!rstn)
		game_tick |=> !game_tick);

endmodule

//--- hw/note_generator.sv
`timescale 1ns/1ps

module note_generator (
	input  logic       clk_1khz,
	input  logic       rstn,
	input  logic       game_tick,
	output logic [7:0] note_top,
	output logic [7:0] note_bottom
);
	import rhythm_pkg::*;

	logic [31:0] seed;
	logic [31:0] seed_next;
	logic [14:0] range_val;
	logic [2:0] note_idx;

	assign seed_next = seed * LCG_MUL + LCG_ADD; // Wraps mod 2^32
	assign range_val = seed_next[30:16];
	assign note_idx = range_val[12:10];

	always_ff @(posedge clk_1khz or negedge rstn) begin
		if (!rstn)
			seed <= 32'd1;
		else if (game_tick)
			seed <= seed_next;
	end

	// Below 8192 one lane gets a note, above that both stay empty
	always_comb begin
		note_top = " ";
		note_bottom = " ";
		if (range_val < 15'd8192) begin
			if (!note_idx[2])
				note_top = note_chars[note_idx];
			else
				note_bottom = note_chars[note_idx];
		end
	end

endmodule

//--- hw/game_core.sv
`timescale 1ns/1ps

module game_core (
	input  logic       clk_1khz,
	input  logic       rstn,
	input  logic       game_tick,
	input  logic [7:0] keys,
	input  logic [7:0] note_top,
	input  logic [7:0] note_bottom,
	play_if.core       play
);
	import rhythm_pkg::*;

	localparam row_t ROW_CLEAR = {":", {(ROW_CHARS - 1){" "}}};

	logic hit_top;
	logic hit_bottom;
	logic miss_top;
	logic miss_bottom;
	logic [14:0] score_sum;
	score_t score_next;
	logic [1:0] misses;
	lives_t lives_next;
	row_t shifted_top;
	row_t shifted_bottom;

	////////////////////
	// Judge column 1

	always_comb begin
		hit_top = 1'b0;
		hit_bottom = 1'b0;
		miss_top = 1'b0;
		miss_bottom = 1'b0;
		for (int i = 0; i < 4; i++) begin
			if (play.row_top[JUDGE_COL] == note_chars[i]) begin
				if (keys[i])
					hit_top = 1'b1;
				else
					miss_top = 1'b1;
			end
			if (play.row_bottom[JUDGE_COL] == note_chars[i + 4]) begin
				if (keys[i + 4])
					hit_bottom = 1'b1;
				else
					miss_bottom = 1'b1;
			end
		end
	end

	// Score with clamp, lives floored at zero
	always_comb begin
		score_sum = {1'b0, play.score};
		if (hit_top)
			score_sum = score_sum + 15'(HIT_POINTS);
		if (hit_bottom)
			score_sum = score_sum + 15'(HIT_POINTS);
		if (score_sum > 15'(SCORE_MAX))
			score_next = score_t'(SCORE_MAX);
		else
			score_next = score_sum[13:0];

		misses = {1'b0, miss_top} + {1'b0, miss_bottom};
		if (play.lives > lives_t'(misses))
			lives_next = play.lives - lives_t'(misses);
		else
			lives_next = '0;
	end

	// Drop column 1, new note enters at the right end
	assign shifted_top = {":", play.row_top[JUDGE_COL + 1:ROW_CHARS - 1], note_top};
	assign shifted_bottom = {":", play.row_bottom[JUDGE_COL + 1:ROW_CHARS - 1], note_bottom};

	////////////////////
	// Game state

	always_ff @(posedge clk_1khz or negedge rstn) begin
		if (!rstn) begin
			play.row_top <= ROW_CLEAR;
			play.row_bottom <= ROW_CLEAR;
			play.score <= '0;
			play.lives <= lives_t'(LIVES_START);
			play.game_over <= 1'b0;
		end else if (game_tick && !play.game_over) begin
			play.score <= score_next;
			play.lives <= lives_next;
			if (lives_next == '0) begin
				play.row_top <= END_TOP; // End screen, everything frozen from here
				play.row_bottom <= END_BOTTOM;
				play.game_over <= 1'b1;
			end else begin
				play.row_top <= shifted_top;
				play.row_bottom <= shifted_bottom;
			end
		end
	end

	a_lives_down: assert property (@(posedge clk_1khz) disable iff (!rstn)
		play.lives <= $past(play.lives));

	a_score_max: assert property (@(posedge clk_1khz) disable iff (!rstn)
		play.score <= score_t'(SCORE_MAX));

endmodule

//--- hw/lcd_writer.sv
`timescale 1ns/1ps

module lcd_writer #(
	parameter int INIT_WAIT = 700,
	parameter int CMD_WAIT  = 300
) (
	input  logic       clk_1khz,
	input  logic       rstn,
	play_if.lcd        play,
	output logic       lcd_ready,
	output logic       lcd_rs,
	output logic       lcd_rw,
	output logic [7:0] lcd_data
);
	import rhythm_pkg::*;

	localparam int LINE_LAST = ROW_CHARS + 8; // Address, 16 chars, 8 idle
	localparam int WAIT_MAX = (INIT_WAIT > CMD_WAIT) ? INIT_WAIT : CMD_WAIT;
	localparam int CNT_MAX = (WAIT_MAX > LINE_LAST) ? WAIT_MAX : LINE_LAST;
	localparam int CNT_W = $clog2(CNT_MAX + 1);

	typedef enum logic [2:0] {
		ST_DELAY, ST_FUNC, ST_DISP, ST_ENTRY, ST_LINE1, ST_LINE2
	} state_e;

	state_e state;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] limit;
	row_t row_sel;
	logic [7:0] line_addr;
	logic [3:0] char_idx;

	////////////////////
	// State and phase counter

	always_comb begin
		case (state)
			ST_DELAY: limit = CNT_W'(INIT_WAIT);
			ST_FUNC, ST_DISP, ST_ENTRY: limit = CNT_W'(CMD_WAIT);
			default: limit = CNT_W'(LINE_LAST);
		endcase
	end

	always_ff @(posedge clk_1khz or negedge rstn) begin
		if (!rstn) begin
			state <= ST_DELAY;
			cnt <= '0;
		end else if (cnt == limit) begin
			cnt <= '0;
			case (state)
				ST_DELAY: state <= ST_FUNC;
				ST_FUNC:  state <= ST_DISP;
				ST_DISP:  state <= ST_ENTRY;
				ST_ENTRY: state <= ST_LINE1;
				ST_LINE1: state <= ST_LINE2;
				default:  state <= ST_LINE1; // Rows alternate forever
			endcase
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign lcd_ready = (state == ST_LINE1) || (state == ST_LINE2);

	////////////////////
	// Bus drive

	assign row_sel = (state == ST_LINE1) ? play.row_top : play.row_bottom;
	assign line_addr = (state == ST_LINE1) ? LINE1_ADDR : LINE2_ADDR;
	assign char_idx = 4'(cnt - 1'b1);

	always_ff @(posedge clk_1khz or negedge rstn) begin
		if (!rstn) begin
			lcd_rs <= 1'b1;
			lcd_rw <= 1'b1;
			lcd_data <= 8'h00;
		end else begin
			case (state)
				ST_FUNC: begin
					lcd_rs <= 1'b0;
					lcd_rw <= 1'b0;
					lcd_data <= FUNCTION_SET;
				end
				ST_DISP: begin
					lcd_rs <= 1'b0;
					lcd_rw <= 1'b0;
					lcd_data <= DISP_ON;
				end
				ST_ENTRY: begin
					lcd_rs <= 1'b0;
					lcd_rw <= 1'b0;
					lcd_data <= ENTRY_MODE;
				end
				ST_LINE1, ST_LINE2: begin
					lcd_rw <= 1'b0;
					if (cnt == '0) begin
						lcd_rs <= 1'b0;
						lcd_data <= line_addr;
					end else if (cnt <= CNT_W'(ROW_CHARS)) begin
						lcd_rs <= 1'b1;
						lcd_data <= row_sel[char_idx];
					end // Idle tail keeps the last byte
				end
				default: begin
					lcd_rs <= 1'b1;
					lcd_rw <= 1'b1;
					lcd_data <= 8'h00;
				end
			endcase
		end
	end

	a_rw_low: assert property (@(posedge clk_1khz) disable iff (!rstn)
		(state != ST_DELAY) |=> !lcd_rw);

endmodule

//--- hw/status_display.sv
`timescale 1ns/1ps

module status_display (
	input  logic       clk_1khz,
	input  logic       rstn,
	play_if.status     play,
	output logic [3:0] seg_com,
	output logic [7:0] seg_data,
	output logic [7:0] single_fnd
);
	import rhythm_pkg::*;

	// Place values of digits 3..1, digit 0 is what remains
	localparam logic [3:1][13:0] PLACE = {14'd1000, 14'd100, 14'd10};

	logic [13:0] rem;
	logic [3:0][3:0] digits;
	logic [1:0] ptr;

	////////////////////
	// Score to BCD

	always_comb begin
		rem = play.score;
		digits = '0;
		for (int d = 3; d >= 1; d--) begin
			for (int k = 0; k < 9; k++) begin
				if (rem >= PLACE[d]) begin
					rem = rem - PLACE[d];
					digits[d] = digits[d] + 4'd1;
				end
			end
		end
		digits[0] = rem[3:0];
	end

	// One digit per clock, thousands first
	always_ff @(posedge clk_1khz or negedge rstn) begin
		if (!rstn) begin
			ptr <= '0;
			seg_com <= 4'b1111;
			seg_data <= 8'h00;
			single_fnd <= 8'h00;
		end else begin
			ptr <= ptr + 1'b1;
			seg_com <= ~(4'b1000 >> ptr); // Active low
			seg_data <= seg_digit[digits[2'd3 - ptr]];
			single_fnd <= seg_digit[play.lives];
		end
	end

endmodule

//--- hw/rhythm_top.sv
`timescale 1ns/1ps

module rhythm_top #(
	parameter int GAME_DIV  = 250,
	parameter int INIT_WAIT = 700,
	parameter int CMD_WAIT  = 300
) (
	input  logic       clk_1khz,
	input  logic       rstn,
	input  logic [7:0] keys,
	output logic       lcd_e,
	output logic       lcd_rs,
	output logic       lcd_rw,
	output logic [7:0] lcd_data,
	output logic [3:0] seg_com,
	output logic [7:0] seg_data,
	output logic [7:0] single_fnd
);

	logic lcd_ready;
	logic game_tick;
	logic [7:0] note_top;
	logic [7:0] note_bottom;

	play_if i_play ();

	assign lcd_e = clk_1khz; // LCD latches on every clock

	tick_divider #(.GAME_DIV(GAME_DIV)) i_tick (
		.clk_1khz (clk_1khz),
		.rstn     (rstn),
		.lcd_ready(lcd_ready),
		.game_tick(game_tick)
	);

	note_generator i_notes (
		.clk_1khz   (clk_1khz),
		.rstn       (rstn),
		.game_tick  (game_tick),
		.note_top   (note_top),
		.note_bottom(note_bottom)
	);

	game_core i_core (
		.clk_1khz   (clk_1khz),
		.rstn       (rstn),
		.game_tick  (game_tick),
		.keys       (keys),
		.note_top   (note_top),
		.note_bottom(note_bottom),
		.play       (i_play.core)
	);

	lcd_writer #(.INIT_WAIT(INIT_WAIT), .CMD_WAIT(CMD_WAIT)) i_lcd (
		.clk_1khz (clk_1khz),
		.rstn     (rstn),
		.play     (i_play.lcd),
		.lcd_ready(lcd_ready),
		.lcd_rs   (lcd_rs),
		.lcd_rw   (lcd_rw),
		.lcd_data (lcd_data)
	);

	status_display i_status (
		.clk_1khz  (clk_1khz),
		.rstn      (rstn),
		.play      (i_play.status),
		.seg_com   (seg_com),
		.seg_data  (seg_data),
		.single_fnd(single_fnd)
	);

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
	parameter int INIT_WAIT = 20,
	parameter int CMD_WAIT  = 10
) (
	input logic              clk_1khz,
	input logic              rstn,
	input logic              lcd_e,
	input logic              lcd_rs,
	input logic              lcd_rw,
	input logic [7:0]        lcd_data,
	input logic [3:0]        seg_com,
	input logic [7:0]        seg_data,
	input logic [7:0]        single_fnd,
	input rhythm_pkg::row_t  exp_top,
	input rhythm_pkg::row_t  exp_bottom,
	input int                exp_score,
	input int                exp_lives,
	input int                model_ver
);
	import rhythm_pkg::*;

	string test_name;
	int test_errs;
	int n_pass;
	int n_fail;
	int stable; // Clocks since the model last changed
	int last_ver;
	row_t cap_row;
	int cap_idx;
	bit cap_bottom;
	int digs[4];
	int last_score;
	int last_lives;

	initial begin
		n_pass = 0;
		n_fail = 0;
		test_errs = 0;
		stable = 0;
		last_ver = 0;
		cap_idx = ROW_CHARS;
		last_score = -1;
		last_lives = -1;
	end

	function automatic int seg_value(input logic [7:0] s);
		for (int i = 0; i < 10; i++)
			if (seg_digit[i] == s) return i;
		return -1;
	endfunction

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		if (test_errs == 0) begin
			n_pass++;
			$display("PASS %s", test_name);
		end else begin
			n_fail++;
			$display("FAIL %s: %0d mismatches", test_name, test_errs);
		end
	endtask

	task automatic check_value(input string what, input int exp, input int act);
		if (exp != act) begin
			test_errs++;
			if (test_errs < 10)
				$display("FAIL %s: %s expected %0d actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		test_errs++;
		$display("ERROR in %s: %s", test_name, msg);
	endtask

	////////////////////
	// Start-up commands

	task automatic check_startup();
		logic [7:0] cmds [3];
		int n;
		cmds = '{8'h3C, 8'h0C, 8'h06};
		@(posedge clk_1khz);
		n = 0;
		@(negedge clk_1khz);
		while (lcd_rs === 1'b1 && lcd_rw === 1'b1 && lcd_data === 8'h00
				&& n <= INIT_WAIT + 50) begin
			n++;
			@(negedge clk_1khz);
		end
		check_value("delay clocks", INIT_WAIT + 1, n);
		for (int c = 0; c < 3; c++) begin
			check_value("command byte", cmds[c], lcd_data);
			check_value("command rs", 0, lcd_rs);
			n = 0;
			while (lcd_rs === 1'b0 && lcd_rw === 1'b0 && lcd_data === cmds[c]
					&& n <= CMD_WAIT + 50) begin
				n++;
				@(negedge clk_1khz);
			end
			check_value("command hold clocks", CMD_WAIT + 1, n);
		end
		check_value("first address", 8'h80, lcd_data);
	endtask

	// LCD enable follows the clock
	always @(clk_1khz) begin
		#5;
		if (rstn)
			check_value("lcd_e", int'(clk_1khz), int'(lcd_e));
	end

	////////////////////
	// Continuous compare

	always @(negedge clk_1khz) begin
		if (!rstn || model_ver != last_ver)
			stable = 0;
		else if (stable < 100000)
			stable++;
		last_ver = model_ver;

		// Row frames from the LCD bus
		if (!rstn) begin
			cap_idx = ROW_CHARS;
		end else if (!lcd_rs && (lcd_data == 8'h80 || lcd_data == 8'hC0)) begin
			cap_bottom = (lcd_data == 8'hC0);
			cap_idx = 0;
		end else if (lcd_rs && cap_idx < ROW_CHARS) begin
			cap_row[cap_idx] = lcd_data;
			cap_idx++;
			if (cap_idx == ROW_CHARS && stable >= 20) begin
				if (cap_row != (cap_bottom ? exp_bottom : exp_top)) begin
					test_errs++;
					if (test_errs < 10)
						$display("FAIL %s: row %0d expected \"%s\" actual \"%s\"", test_name,
							cap_bottom, cap_bottom ? exp_bottom : exp_top, cap_row);
				end
			end
		end

		// Multiplexed score with thousands first
		if (rstn) begin
			case (seg_com)
				4'b0111: digs[3] = seg_value(seg_data);
				4'b1011: digs[2] = seg_value(seg_data);
				4'b1101: digs[1] = seg_value(seg_data);
				4'b1110: begin
					digs[0] = seg_value(seg_data);
					if (stable >= 8) begin
						last_score = digs[3] * 1000 + digs[2] * 100 + digs[1] * 10 + digs[0];
						check_value("score", exp_score, last_score);
					end
				end
				default: ;
			endcase
			if (stable >= 3) begin
				last_lives = seg_value(single_fnd);
				check_value("lives digit", exp_lives, last_lives);
			end
		end
	end

endmodule

//--- testbench/tb_rhythm.sv
`timescale 1ns/1ps

module tb_rhythm;
	import rhythm_pkg::*;

	localparam int GAME_DIV = 40;
	localparam int INIT_WAIT = 20;
	localparam int CMD_WAIT = 10;
	localparam int TICK_LIMIT = INIT_WAIT + 4 * (CMD_WAIT + 1) + 4 * GAME_DIV + 100;

	logic clk_1khz;
	logic rstn;
	logic [7:0] keys;
	logic lcd_e;
	logic lcd_rs;
	logic lcd_rw;
	logic [7:0] lcd_data;
	logic [3:0] seg_com;
	logic [7:0] seg_data;
	logic [7:0] single_fnd;

	integer seed;
	int mode; // 0 keys released, 1 perfect play
	logic [7:0] next_keys;
	logic s_rstn;
	logic s_ready;
	logic [7:0] s_keys;
	bit stalled;

	// Reference state
	logic [31:0] m_seed;
	row_t m_top;
	row_t m_bottom;
	int m_score;
	int m_lives;
	bit m_over;
	int m_ver;
	int m_cnt;
	bit m_tick;
	int tick_count;
	int exp_val;
	int guard;

	initial begin
		clk_1khz = 1'b0;
		forever #10 clk_1khz = ~clk_1khz;
	end

	rhythm_top #(.GAME_DIV(GAME_DIV), .INIT_WAIT(INIT_WAIT), .CMD_WAIT(CMD_WAIT)) i_dut (
		.clk_1khz  (clk_1khz),
		.rstn      (rstn),
		.keys      (keys),
		.lcd_e     (lcd_e),
		.lcd_rs    (lcd_rs),
		.lcd_rw    (lcd_rw),
		.lcd_data  (lcd_data),
		.seg_com   (seg_com),
		.seg_data  (seg_data),
		.single_fnd(single_fnd)
	);

	tb_checker #(.INIT_WAIT(INIT_WAIT), .CMD_WAIT(CMD_WAIT)) i_chk (
		.clk_1khz  (clk_1khz),
		.rstn      (rstn),
		.lcd_e     (lcd_e),
		.lcd_rs    (lcd_rs),
		.lcd_rw    (lcd_rw),
		.lcd_data  (lcd_data),
		.seg_com   (seg_com),
		.seg_data  (seg_data),
		.single_fnd(single_fnd),
		.exp_top   (m_top),
		.exp_bottom(m_bottom),
		.exp_score (m_score),
		.exp_lives (m_lives),
		.model_ver (m_ver)
	);

	////////////////////
	// Reference model

	function automatic void model_clear();
		m_seed = 32'd1;
		m_top = {":", {(ROW_CHARS - 1){" "}}};
		m_bottom = m_top;
		m_score = 0;
		m_lives = LIVES_START;
		m_over = 1'b0;
		m_cnt = 0;
		m_tick = 1'b0;
		m_ver++;
	endfunction

	function automatic void model_tick(input logic [7:0] k);
		int r;
		int misses;
		logic [7:0] nt;
		logic [7:0] nb;
		m_seed = m_seed * LCG_MUL + LCG_ADD;
		r = int'(m_seed[30:16]);
		nt = " ";
		nb = " ";
		if (r < 8192) begin
			if (r / 1024 < 4)
				nt = note_chars[r / 1024];
			else
				nb = note_chars[r / 1024];
		end
		misses = 0;
		for (int i = 0; i < 4; i++) begin
			if (m_top[JUDGE_COL] == note_chars[i]) begin
				if (k[i]) m_score += HIT_POINTS;
				else misses++;
			end
			if (m_bottom[JUDGE_COL] == note_chars[i + 4]) begin
				if (k[i + 4]) m_score += HIT_POINTS;
				else misses++;
			end
		end
		if (m_score > SCORE_MAX) m_score = SCORE_MAX;
		m_lives = (m_lives > misses) ? m_lives - misses : 0;
		if (m_lives == 0) begin
			m_over = 1'b1;
			m_top = END_TOP;
			m_bottom = END_BOTTOM;
		end else begin
			for (int c = 1; c < ROW_CHARS - 1; c++) begin
				m_top[c] = m_top[c + 1];
				m_bottom[c] = m_bottom[c + 1];
			end
			m_top[ROW_CHARS - 1] = nt;
			m_bottom[ROW_CHARS - 1] = nb;
		end
		m_ver++;
	endfunction

	// Keys that hit whatever sits in the judged column
	function automatic logic [7:0] keys_for(input row_t top, input row_t bottom);
		logic [7:0] k;
		k = 8'h00;
		for (int i = 0; i < 4; i++) begin
			if (top[JUDGE_COL] == note_chars[i]) k[i] = 1'b1;
			if (bottom[JUDGE_COL] == note_chars[i + 4]) k[i + 4] = 1'b1;
		end
		return k;
	endfunction

	always @(negedge clk_1khz) begin
		s_rstn = rstn;
		s_ready = i_dut.lcd_ready;
		s_keys = keys;
		if (mode == 1)
			next_keys = keys_for(m_top, m_bottom) | 8'($random(seed));
		else
			next_keys = 8'h00;
	end

	// Tick rebuilt from lcd_ready every GAME_DIV clocks
	always @(posedge clk_1khz) begin
		if (!s_rstn) begin
			model_clear();
		end else begin
			if (m_tick) begin
				tick_count++;
				if (!m_over) model_tick(s_keys);
			end
			if (!s_ready) begin
				m_cnt = 0;
				m_tick = 1'b0;
			end else if (m_cnt == GAME_DIV - 1) begin
				m_cnt = 0;
				m_tick = 1'b1;
			end else begin
				m_cnt++;
				m_tick = 1'b0;
			end
		end
	end

	always @(posedge clk_1khz) keys <= next_keys;

	////////////////////
	// Sequencing helpers

	task automatic wait_ticks(input int n);
		int start;
		int cnt;
		for (int j = 0; j < n && !stalled; j++) begin
			start = tick_count;
			cnt = 0;
			while (tick_count == start && cnt < TICK_LIMIT) begin
				@(negedge clk_1khz);
				cnt++;
			end
			if (tick_count == start) begin
				stalled = 1'b1;
				i_chk.report_error($sformatf("no game tick seen within %0d clocks", TICK_LIMIT));
			end
		end
	endtask

	task automatic set_mode(input int v);
		@(posedge clk_1khz);
		mode = v;
	endtask

	task automatic pulse_reset();
		@(posedge clk_1khz);
		rstn <= 1'b0;
		repeat (3) @(posedge clk_1khz);
		rstn <= 1'b1;
	endtask

	initial begin
		seed = 32'hefe9_a5b7;
		rstn = 1'b0;
		keys = 8'h00;
		mode = 0;
		next_keys = 8'h00;
		s_rstn = 1'b0;
		s_ready = 1'b0;
		stalled = 1'b0;
		m_ver = 0;
		tick_count = 0;
		model_clear();
		repeat (3) @(posedge clk_1khz);
		rstn <= 1'b1;

		i_chk.begin_test("startup");
		i_chk.check_startup();
		i_chk.end_test();

		i_chk.begin_test("note_scrolling");
		wait_ticks(10);
		i_chk.end_test();

		i_chk.begin_test("hits_score");
		set_mode(1);
		wait_ticks(60);
		repeat (16) @(posedge clk_1khz);
		i_chk.check_value("lives", LIVES_START, i_chk.last_lives);
		i_chk.end_test();

		i_chk.begin_test("misses_cost_lives");
		set_mode(0);
		guard = 0;
		while (m_lives > 3 && guard < 300 && !stalled) begin
			wait_ticks(1);
			guard++;
		end
		if (guard >= 300)
			i_chk.report_error("lives did not fall to 3 within 300 ticks");
		exp_val = m_lives;
		repeat (16) @(posedge clk_1khz);
		i_chk.check_value("lives", exp_val, i_chk.last_lives);
		i_chk.end_test();

		i_chk.begin_test("game_over");
		guard = 0;
		while (!m_over && guard < 300 && !stalled) begin
			wait_ticks(1);
			guard++;
		end
		if (guard >= 300)
			i_chk.report_error("game did not end within 300 ticks");
		exp_val = m_score;
		wait_ticks(5); // Frozen from here
		repeat (16) @(posedge clk_1khz);
		i_chk.check_value("frozen score", exp_val, i_chk.last_score);
		i_chk.check_value("frozen lives", 0, i_chk.last_lives);
		i_chk.end_test();

		i_chk.begin_test("score_clamp");
		pulse_reset();
		set_mode(1);
		guard = 0;
		while (m_score < SCORE_MAX && guard < 3000 && !stalled) begin
			wait_ticks(1);
			guard++;
		end
		if (guard >= 3000)
			i_chk.report_error("score did not reach the limit within 3000 ticks");
		wait_ticks(3);
		repeat (16) @(posedge clk_1khz);
		i_chk.check_value("clamped score", SCORE_MAX, i_chk.last_score);
		i_chk.end_test();

		$display("Tests: %0d passed, %0d failed", i_chk.n_pass, i_chk.n_fail);
		if (i_chk.n_fail == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- list.f
hw/rhythm_pkg.sv
hw/play_if.sv
hw/tick_divider.sv
hw/note_generator.sv
hw/game_core.sv
hw/lcd_writer.sv
hw/status_display.sv
hw/rhythm_top.sv
testbench/tb_checker.sv
testbench/tb_rhythm.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_rhythm -f list.f -o sim_rhythm \
	&& ./obj_dir/sim_rhythm > sim.log 2>&1
cat sim.log
grep -q "Verification passed" sim.log && exit 0 || exit 1
